// File: logic/mig_pkg.sv
`default_nettype none

// Native user interface of the DDR controller, single-beat lines.
package mig_pkg;

   localparam int app_addr_w = 28;
   localparam int line_w     = 512;
   localparam int line_bytes = line_w / 8;    // Also the mask width.

   // Command encodings as seen on app_cmd.
   typedef enum logic [2:0]
   {
      cmd_write = 3'd0,
      cmd_read  = 3'd1
   } app_cmd_e;

   // Low three address bits stay zero. A line is eight 64-bit columns.
   typedef struct packed
   {
      logic                  en;
      app_cmd_e              cmd;
      logic [app_addr_w-1:0] addr;
   } app_req_t;

   // A mask bit of one keeps the stored byte.
   typedef struct packed
   {
      logic                  wren;
      logic                  last;    // wdf_end.
      logic [line_w-1:0]     data;
      logic [line_bytes-1:0] mask;
   } app_wdf_t;

   typedef struct packed
   {
      logic              valid;
      logic              last;
      logic [line_w-1:0] data;
   } app_rd_t;

endpackage

`default_nettype wire

// File: logic/mig_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mig_subsystem_top #(
   parameter int mem_lines_log2   = 10,
   parameter int rd_latency       = 6,
   parameter int calib_cycles     = 1024 + 40,    // Covers the memory clear sweep.
   parameter int refresh_interval = 64,
   parameter int refresh_cycles   = 5
) (
   input  logic            ui_clk,
   input  logic            rst,
   input  wb_pkg::wb_req_t wb_req,
   output wb_pkg::wb_rsp_t wb_rsp,
   output logic            init_calib_complete
);

   mig_pkg::app_req_t app_req;
   mig_pkg::app_wdf_t app_wdf;
   mig_pkg::app_rd_t  app_rd;
   logic              app_rdy;
   logic              app_wdf_rdy;

   wb_mig_bridge wb_mig_bridge_i (
      .ui_clk      (ui_clk),
      .rst         (rst),
      .wb_req      (wb_req),
      .wb_rsp      (wb_rsp),
      .app_req     (app_req),
      .app_wdf     (app_wdf),
      .app_rdy     (app_rdy),
      .app_wdf_rdy (app_wdf_rdy),
      .app_rd      (app_rd)
   );

   mig_ui_model #(
      .mem_lines_log2   (mem_lines_log2),
      .rd_latency       (rd_latency),
      .calib_cycles     (calib_cycles),
      .refresh_interval (refresh_interval),
      .refresh_cycles   (refresh_cycles)
   ) mig_ui_model_i (
      .ui_clk              (ui_clk),
      .rst                 (rst),
      .app_req             (app_req),
      .app_wdf             (app_wdf),
      .app_rdy             (app_rdy),
      .app_wdf_rdy         (app_wdf_rdy),
      .app_rd              (app_rd),
      .init_calib_complete (init_calib_complete)
   );

endmodule

`default_nettype wire

// File: logic/mig_ui_model.sv
`timescale 1ns/1ps
`default_nettype none

module mig_ui_model #(
   parameter int mem_lines_log2   = 10,
   parameter int rd_latency       = 6,
   parameter int calib_cycles     = 1064,
   parameter int refresh_interval = 64,
   parameter int refresh_cycles   = 5
) (
   input  logic              ui_clk,
   input  logic              rst,
   input  mig_pkg::app_req_t app_req,
   input  mig_pkg::app_wdf_t app_wdf,
   output logic              app_rdy,
   output logic              app_wdf_rdy,
   output mig_pkg::app_rd_t  app_rd,
   output logic              init_calib_complete
);

   localparam int lines     = 1 << mem_lines_log2;
   localparam int calib_w   = $clog2(calib_cycles + 1);
   localparam int refresh_w = $clog2(refresh_interval);

   logic [calib_w-1:0]               calib_cnt;
   logic [refresh_w-1:0]             refresh_cnt;
   logic                             refresh_busy;

   logic [1:0]                       wdf_count;
   logic                             wdf_wr_ptr;
   logic                             wdf_rd_ptr;
   logic [mig_pkg::line_w-1:0]       wdf_data [2];
   logic [mig_pkg::line_bytes-1:0]   wdf_mask [2];
   logic                             wdf_push;
   logic                             wdf_pop;

   logic                             cmd_write_acc;
   logic                             cmd_read_acc;
   logic [mem_lines_log2-1:0]        line_idx;
   logic [mig_pkg::line_w-1:0]       mem [lines];
   logic [mig_pkg::line_w-1:0]       old_line;
   logic [mig_pkg::line_w-1:0]       merged_line;

   logic [rd_latency-1:0]            rd_valid_sr;
   logic [mig_pkg::line_w-1:0]       rd_data_sr [rd_latency];

   // Calibration window. The memory is swept clear during it.
   always_ff @(posedge ui_clk)
   begin
      if (rst)
      begin
         calib_cnt           <= '0;
         init_calib_complete <= 1'b0;
      end
      else if (!init_calib_complete)
      begin
         if (calib_cnt == calib_w'(calib_cycles - 1))
            init_calib_complete <= 1'b1;
         calib_cnt <= calib_cnt + 1'b1;
      end
   end

   // Refresh slot sits at the end of every interval.
   always_ff @(posedge ui_clk)
   begin
      if (rst)
         refresh_cnt <= '0;
      else if (init_calib_complete)
      begin
         if (refresh_cnt == refresh_w'(refresh_interval - 1))
            refresh_cnt <= '0;
         else
            refresh_cnt <= refresh_cnt + 1'b1;
      end
   end

   assign refresh_busy = refresh_cnt >= refresh_w'(refresh_interval - refresh_cycles);

   // A write command needs a buffered beat to consume.
   assign app_rdy = init_calib_complete && !refresh_busy &&
                    !(app_req.en && app_req.cmd == mig_pkg::cmd_write && wdf_count == 2'd0);

   assign app_wdf_rdy = wdf_count != 2'd2;

   assign wdf_push      = app_wdf.wren && app_wdf_rdy;
   assign cmd_write_acc = app_req.en && app_rdy && app_req.cmd == mig_pkg::cmd_write;
   assign cmd_read_acc  = app_req.en && app_rdy && app_req.cmd == mig_pkg::cmd_read;
   assign wdf_pop       = cmd_write_acc;

   always_ff @(posedge ui_clk)
   begin
      if (rst)
      begin
         wdf_count  <= '0;
         wdf_wr_ptr <= 1'b0;
         wdf_rd_ptr <= 1'b0;
      end
      else
      begin
         if (wdf_push)
            wdf_wr_ptr <= ~wdf_wr_ptr;
         if (wdf_pop)
            wdf_rd_ptr <= ~wdf_rd_ptr;
         wdf_count <= wdf_count + 2'(wdf_push) - 2'(wdf_pop);
      end
   end

   always_ff @(posedge ui_clk)
   begin
      if (wdf_push)
      begin
         wdf_data[wdf_wr_ptr] <= app_wdf.data;
         wdf_mask[wdf_wr_ptr] <= app_wdf.mask;
      end
   end

   assign line_idx = app_req.addr[3 +: mem_lines_log2];    // Higher lines alias.
   assign old_line = mem[line_idx];

   // Byte merge of the oldest beat under its mask.
   always_comb
   begin
      for (int b = 0; b < mig_pkg::line_bytes; b++)
      begin
         if (wdf_mask[wdf_rd_ptr][b])
            merged_line[8*b +: 8] = old_line[8*b +: 8];
         else
            merged_line[8*b +: 8] = wdf_data[wdf_rd_ptr][8*b +: 8];
      end
   end

   always_ff @(posedge ui_clk)
   begin
      if (!init_calib_complete)
         mem[calib_cnt[mem_lines_log2-1:0]] <= '0;    // One line per cycle.
      else if (cmd_write_acc)
         mem[line_idx] <= merged_line;
   end

   // Read pipeline. Line is sampled in the accept cycle.
   always_ff @(posedge ui_clk)
   begin
      if (rst)
         rd_valid_sr <= '0;
      else
      begin
         rd_valid_sr[0] <= cmd_read_acc;
         for (int i = 1; i < rd_latency; i++)
            rd_valid_sr[i] <= rd_valid_sr[i-1];
      end
   end

   always_ff @(posedge ui_clk)
   begin
      rd_data_sr[0] <= old_line;
      for (int i = 1; i < rd_latency; i++)
         rd_data_sr[i] <= rd_data_sr[i-1];
   end

   assign app_rd.valid = rd_valid_sr[rd_latency-1];
   assign app_rd.last  = rd_valid_sr[rd_latency-1];    // Single beat per command.
   assign app_rd.data  = rd_data_sr[rd_latency-1];

endmodule

`default_nettype wire

// File: logic/wb_mig_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mig_bridge (
   input  logic              ui_clk,
   input  logic              rst,
   input  wb_pkg::wb_req_t   wb_req,
   output wb_pkg::wb_rsp_t   wb_rsp,
   output mig_pkg::app_req_t app_req,
   output mig_pkg::app_wdf_t app_wdf,
   input  logic              app_rdy,
   input  logic              app_wdf_rdy,
   input  mig_pkg::app_rd_t  app_rd
);

   localparam int lane_w   = $clog2(mig_pkg::line_w / wb_pkg::wb_dat_w);
   localparam int line_lsb = 2 + lane_w;    // Wishbone byte address bit of the line number.
   localparam int col_bits = 3;
   localparam int row_w    = mig_pkg::app_addr_w - col_bits;

   typedef enum logic [1:0]
   {
      st_idle,
      st_issue,
      st_wait_data,
      st_ack
   } state_e;

   state_e                           state;
   logic                             en_q;
   logic                             wren_q;
   logic                             we_q;
   logic [lane_w-1:0]                lane_q;
   logic [mig_pkg::app_addr_w-1:0]   addr_q;
   logic [mig_pkg::line_w-1:0]       line_data_q;
   logic [mig_pkg::line_bytes-1:0]   line_mask_q;
   logic [wb_pkg::wb_dat_w-1:0]      rd_word_q;

   logic [lane_w-1:0]                lane_in;
   logic [mig_pkg::app_addr_w-1:0]   addr_in;
   logic [mig_pkg::line_w-1:0]       line_data_in;
   logic [mig_pkg::line_bytes-1:0]   line_mask_in;
   logic                             start;
   logic                             cmd_done;
   logic                             wdf_done;

   assign start   = state == st_idle && wb_req.cyc && wb_req.stb;
   assign lane_in = wb_req.adr[2 +: lane_w];
   assign addr_in = {wb_req.adr[line_lsb +: row_w], col_bits'(0)};

   // Word goes to its lane. Every other byte stays masked.
   always_comb
   begin
      line_data_in = '0;
      line_mask_in = '1;
      line_data_in[lane_in*wb_pkg::wb_dat_w +: wb_pkg::wb_dat_w] = wb_req.dat;
      line_mask_in[lane_in*wb_pkg::wb_sel_w +: wb_pkg::wb_sel_w] = ~wb_req.sel;
   end

   assign cmd_done = !en_q || app_rdy;
   assign wdf_done = !wren_q || app_wdf_rdy;

   always_ff @(posedge ui_clk)
   begin
      if (rst)
      begin
         state  <= st_idle;
         en_q   <= 1'b0;
         wren_q <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
               if (start)
               begin
                  en_q   <= 1'b1;
                  wren_q <= wb_req.we;    // Beat and command go out together.
                  state  <= st_issue;
               end
            st_issue:
            begin
               if (app_rdy)
                  en_q <= 1'b0;
               if (app_wdf_rdy)
                  wren_q <= 1'b0;
               if (cmd_done && wdf_done)
                  state <= we_q ? st_ack : st_wait_data;
            end
            st_wait_data:
               if (app_rd.valid && app_rd.last)
                  state <= st_ack;
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge ui_clk)
   begin
      if (start)
      begin
         we_q        <= wb_req.we;
         lane_q      <= lane_in;
         addr_q      <= addr_in;
         line_data_q <= line_data_in;
         line_mask_q <= line_mask_in;
      end
      if (state == st_wait_data && app_rd.valid)
         rd_word_q <= app_rd.data[lane_q*wb_pkg::wb_dat_w +: wb_pkg::wb_dat_w];
   end

   assign app_req.en   = en_q;
   assign app_req.cmd  = we_q ? mig_pkg::cmd_write : mig_pkg::cmd_read;
   assign app_req.addr = addr_q;

   assign app_wdf.wren = wren_q;
   assign app_wdf.last = wren_q;
   assign app_wdf.data = line_data_q;
   assign app_wdf.mask = line_mask_q;

   assign wb_rsp.ack = state == st_ack;
   assign wb_rsp.dat = rd_word_q;

endmodule

`default_nettype wire

// File: logic/wb_pkg.sv
`default_nettype none

// Wishbone classic slave side, byte addressed.
package wb_pkg;

   localparam int wb_adr_w = 32;
   localparam int wb_dat_w = 32;
   localparam int wb_sel_w = wb_dat_w / 8;

   typedef struct packed
   {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [wb_adr_w-1:0] adr;
      logic [wb_dat_w-1:0] dat;
      logic [wb_sel_w-1:0] sel;
   } wb_req_t;

   typedef struct packed
   {
      logic                ack;    // One-cycle pulse.
      logic [wb_dat_w-1:0] dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module mig_subsystem_tb \
   --Mdir obj_dir -o mig_subsystem_sim \
   -f vlog.f

./obj_dir/mig_subsystem_sim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log
then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// File: tests/mig_subsystem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mig_ui_checker (
   input logic              ui_clk,
   input logic              rst,
   input mig_pkg::app_req_t app_req,
   input mig_pkg::app_wdf_t app_wdf,
   input logic              app_rdy,
   input logic              app_wdf_rdy,
   input mig_pkg::app_rd_t  app_rd,
   input logic              init_calib_complete
);

   cmd_held: assert property (@(posedge ui_clk) disable iff (rst)
      app_req.en && !app_rdy |=> app_req.en && $stable(app_req))
      else $error("Command request changed while app_rdy was low");

   wdf_held: assert property (@(posedge ui_clk) disable iff (rst)
      app_wdf.wren && !app_wdf_rdy |=> $stable(app_wdf))
      else $error("Write data beat changed while app_wdf_rdy was low");

   rd_single: assert property (@(posedge ui_clk) disable iff (rst)
      app_rd.valid |=> !app_rd.valid)
      else $error("Read valid lasted more than one cycle");

   // No command is taken while the controller calibrates.
   rdy_after_calib: assert property (@(posedge ui_clk) disable iff (rst)
      !init_calib_complete |-> !app_rdy)
      else $error("app_rdy high before calibration");

endmodule

bind mig_ui_model mig_ui_checker mig_ui_checker_i (
   .ui_clk              (ui_clk),
   .rst                 (rst),
   .app_req             (app_req),
   .app_wdf             (app_wdf),
   .app_rdy             (app_rdy),
   .app_wdf_rdy         (app_wdf_rdy),
   .app_rd              (app_rd),
   .init_calib_complete (init_calib_complete)
);

`default_nettype wire

// File: tests/mig_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mig_subsystem_tb;

   localparam int mem_lines_log2   = 10;
   localparam int rd_latency       = 6;
   localparam int calib_cycles     = 1024 + 40;
   localparam int refresh_interval = 64;
   localparam int refresh_cycles   = 5;
   localparam int random_ops       = 300;
   localparam int timeout_limit    =
      2 * ((calib_cycles + 10) + random_ops * (rd_latency + refresh_cycles + 6));
   localparam logic [31:0] word_mask  = (32'd1 << (mem_lines_log2 + 4)) - 32'd1;
   localparam logic [31:0] alias_step = 32'd1 << (mem_lines_log2 + 6);    // Next aliasing line.

   logic            ui_clk;
   logic            rst;
   wb_pkg::wb_req_t wb_req;
   wb_pkg::wb_rsp_t wb_rsp;
   logic            init_calib_complete;

   logic [31:0]     ref_mem [logic [31:0]];    // Word address to word.
   wb_pkg::wb_rsp_t exp_rsp;
   logic [31:0]     exp_adr;
   logic            exp_read;
   int              errors;
   int              accesses;
   int              acks;
   int              cycle_count;
   int              calib_wait;    // Cycles since reset was released.

   mig_subsystem_top #(
      .mem_lines_log2   (mem_lines_log2),
      .rd_latency       (rd_latency),
      .calib_cycles     (calib_cycles),
      .refresh_interval (refresh_interval),
      .refresh_cycles   (refresh_cycles)
   ) mig_subsystem_top_i (
      .ui_clk              (ui_clk),
      .rst                 (rst),
      .wb_req              (wb_req),
      .wb_rsp              (wb_rsp),
      .init_calib_complete (init_calib_complete)
   );

   always #5 ui_clk = ~ui_clk;

   function automatic logic [31:0] expected_word(input logic [31:0] adr);
      logic [31:0] key;
      key = (adr >> 2) & word_mask;
      if (ref_mem.exists(key))
         return ref_mem[key];
      return '0;    // Memory is cleared during calibration.
   endfunction

   task automatic ref_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      logic [31:0] word;
      word = expected_word(adr);
      for (int b = 0; b < 4; b++)
         if (sel[b])
            word[8*b +: 8] = dat[8*b +: 8];
      ref_mem[(adr >> 2) & word_mask] = word;
   endtask

   task automatic check_rd_word(input wb_pkg::wb_rsp_t actual, input wb_pkg::wb_rsp_t expected,
                                input logic [31:0] adr);
      if (actual.dat !== expected.dat)
      begin
         $display("Fail wb_rsp.dat at adr 0x%08h expected 0x%08h actual 0x%08h",
                  adr, expected.dat, actual.dat);
         errors++;
      end
   endtask

   task automatic check_calib(input wb_pkg::wb_rsp_t actual, input logic calib,
                              input logic exp_calib);
      if (calib !== exp_calib)
      begin
         $display("Fail init_calib_complete expected 0x%0h actual 0x%0h", exp_calib, calib);
         errors++;
      end
      if (actual.ack && !calib)
      begin
         $display("Acknowledge arrived before calibration was complete");
         errors++;
      end
   endtask

   // One access, held until its ack is seen.
   task automatic wb_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel);
      wb_req   <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
      exp_read <= !we;
      exp_adr  <= adr;
      exp_rsp  <= '{ack: 1'b1, dat: expected_word(adr)};
      if (we)
         ref_write(adr, dat, sel);
      accesses++;
      @(posedge ui_clk);
      while (!wb_rsp.ack)
         @(posedge ui_clk);
   endtask

   task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      wb_access(1'b1, adr, dat, sel);
   endtask

   task automatic read_word(input logic [31:0] adr);
      wb_access(1'b0, adr, '0, 4'hf);
   endtask

   always @(posedge ui_clk)
   begin
      if (rst)
         calib_wait = 0;
      else
      begin
         check_calib(wb_rsp, init_calib_complete, calib_wait >= calib_cycles);
         if (calib_wait < calib_cycles)
            calib_wait++;
         if (wb_rsp.ack)
         begin
            acks++;
            if (!(wb_req.cyc && wb_req.stb))
            begin
               $display("Acknowledge arrived with no access pending");
               errors++;
            end
            else if (exp_read)
               check_rd_word(wb_rsp, exp_rsp, exp_adr);
         end
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < timeout_limit)
      begin
         @(posedge ui_clk);
         cycle_count++;
      end
      $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      logic [31:0] adr;
      logic [31:0] line;
      void'($urandom(4024));
      ui_clk     = 1'b0;
      rst        = 1'b1;
      wb_req     = '0;
      exp_rsp    = '0;
      exp_adr    = '0;
      exp_read   = 1'b0;
      errors     = 0;
      accesses   = 0;
      acks       = 0;
      calib_wait = 0;
      repeat (3) @(posedge ui_clk);
      rst <= 1'b0;

      // Issued during calibration.
      write_word(32'h0000_0040, 32'hcafe_f00d, 4'hf);
      read_word(32'h0000_0040);

      for (int i = 0; i < 8; i++)
         write_word(((32'(i) * 32'd97 + 32'd2) << 6) | (32'(i) << 2), $urandom, 4'hf);
      for (int i = 0; i < 8; i++)
      begin
         read_word(((32'(i) * 32'd97 + 32'd2) << 6) | (32'(i) << 2));
         read_word(((32'(i) * 32'd97 + 32'd2) << 6) | (32'(i + 8) << 2));    // Never written.
      end

      adr = (32'd300 << 6) | (32'd5 << 2);
      write_word(adr, 32'ha1b2_c3d4, 4'hf);
      for (int s = 0; s < 16; s++)
      begin
         write_word(adr, $urandom, s[3:0]);
         read_word(adr);
      end
      read_word(adr + 32'd4);

      // All lanes of one line, then a partial write through its alias.
      for (int l = 0; l < 16; l++)
         write_word((32'd20 << 6) | (32'(l) << 2), $urandom, 4'hf);
      write_word((32'd20 << 6) + alias_step + (32'd7 << 2), $urandom, 4'b1001);
      for (int l = 0; l < 16; l++)
      begin
         read_word((32'd20 << 6) | (32'(l) << 2));
         read_word(((32'd20 << 6) | (32'(l) << 2)) + alias_step);
      end

      for (int n = 0; n < random_ops; n++)
      begin
         line = $urandom_range(3, 0) + ($urandom_range(1, 0) << mem_lines_log2);
         adr  = (line << 6) | ($urandom_range(15, 0) << 2);
         if ($urandom_range(1, 0) == 1)
            write_word(adr, $urandom, 4'($urandom_range(15, 1)));
         else
            read_word(adr);
      end

      wb_req <= '0;
      repeat (rd_latency + 4) @(posedge ui_clk);
      if (acks != accesses)
      begin
         $display("Acknowledge count %0d does not match access count %0d", acks, accesses);
         errors++;
      end
      $display("Errors: %0d, accesses: %0d, acknowledges: %0d", errors, accesses, acks);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
logic/mig_pkg.sv
logic/wb_pkg.sv
logic/mig_ui_model.sv
logic/wb_mig_bridge.sv
logic/mig_subsystem_top.sv
tests/mig_subsystem_checker.sv
tests/mig_subsystem_tb.sv
